// File: include/burst_macros.svh
`ifndef BURST_MACROS_SVH
`define BURST_MACROS_SVH

// external address and offset widths
`define ADDR_W 32
`define OFFSET_W (`ADDR_W / 2)

// words per stage, and the width of one burst length
`define LEN_W 16
`define BURST_W 8

// stage count and its index width
`define N_STAGES 4
`define STAGE_W 2

// cpu register map
`define CFG_ADDR_W 2
`define REG_BASE 2'd0
`define REG_OFFSET 2'd1
`define REG_LEN 2'd2

// multiply-add pipeline depth
`define CALC_LAT 2

`endif

// File: hdl/burst_pkg.sv
`include "burst_macros.svh"

package burst_pkg;

   // one cpu register write
   typedef struct packed {
      logic                   valid;
      logic [`CFG_ADDR_W-1:0] addr;
      logic [`ADDR_W-1:0]     data;
   } cpu_wr_t;

   typedef struct packed {
      logic [`ADDR_W-1:0]   base;
      logic [`OFFSET_W-1:0] offset;
      logic [`LEN_W-1:0]    len;
   } cfg_t;

   // external base address of one stage
   typedef struct packed {
      logic                valid;
      logic [`STAGE_W-1:0] stage;
      logic [`ADDR_W-1:0]  addr;
   } stage_base_t;

   typedef struct packed {
      logic [`STAGE_W-1:0] stage;
      logic [`ADDR_W-1:0]  addr;
      logic [`BURST_W-1:0] len;
   } burst_cmd_t;

endpackage

// File: hdl/cfg_regs.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module cfg_regs (
   input  logic               clk,
   input  logic               rst,
   input  burst_pkg::cpu_wr_t cpu,
   input  logic               run,
   input  logic               busy,
   output burst_pkg::cfg_t    shadow,
   output logic               start
);

   burst_pkg::cfg_t live;

   logic en_base;
   logic en_offset;
   logic en_len;
   logic accept;

   // register write decode
   always_comb begin
      en_base = 1'b0;
      en_offset = 1'b0;
      en_len = 1'b0;
      if (cpu.valid) begin
         case (cpu.addr)
            `REG_BASE:   en_base = 1'b1;
            `REG_OFFSET: en_offset = 1'b1;
            `REG_LEN:    en_len = 1'b1;
            default: ;
         endcase
      end
   end

   // live registers, writable at any time
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         live <= '0;
      end else begin
         if (en_base)
            live.base <= cpu.data;
         if (en_offset)
            live.offset <= cpu.data[`OFFSET_W-1:0];
         if (en_len)
            live.len <= cpu.data[`LEN_W-1:0];
      end
   end

   // run is ignored while a previous run is still going
   assign accept = run & ~busy;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         shadow <= '0;
         start <= 1'b0;
      end else begin
         start <= accept;
         if (accept)
            shadow <= live;
      end
   end

endmodule

// File: hdl/stage_base_calc.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module stage_base_calc (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  burst_pkg::cfg_t        shadow,
   output burst_pkg::stage_base_t base_out
);

   logic                active;
   logic [`STAGE_W-1:0] cnt;
   logic                iss_valid;
   logic [`STAGE_W-1:0] iss_stage;

   logic                p0_valid;
   logic [`STAGE_W-1:0] p0_stage;
   logic [`ADDR_W-1:0]  p0_prod;
   logic                p1_valid;
   logic [`STAGE_W-1:0] p1_stage;
   logic [`ADDR_W-1:0]  p1_addr;

   // stage 0 is issued in the start cycle, the rest follow back to back
   assign iss_valid = start | active;
   assign iss_stage = start ? '0 : cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active <= 1'b0;
         cnt <= '0;
      end else if (start) begin
         active <= (`N_STAGES > 1);
         cnt <= `STAGE_W'(1);
      end else if (active) begin
         cnt <= cnt + 1'b1;
         if (cnt == `STAGE_W'(`N_STAGES - 1))
            active <= 1'b0;
      end
   end

   // valid bits of the two pipeline registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         p0_valid <= 1'b0;
         p1_valid <= 1'b0;
      end else begin
         p0_valid <= iss_valid;
         p1_valid <= p0_valid;
      end
   end

   // index times offset, then plus base
   always_ff @(posedge clk) begin
      p0_stage <= iss_stage;
      p0_prod <= `ADDR_W'(iss_stage) * `ADDR_W'(shadow.offset);
      p1_stage <= p0_stage;
      p1_addr <= shadow.base + p0_prod;
   end

   assign base_out = '{valid: p1_valid, stage: p1_stage, addr: p1_addr};

endmodule

// File: hdl/burst_gen.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module burst_gen #(
   parameter int unsigned STAGE_ID = 0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  burst_pkg::stage_base_t base_in,
   input  burst_pkg::cfg_t        shadow,
   output logic                   cmd_valid,
   output burst_pkg::burst_cmd_t  cmd,
   input  logic                   take,
   output logic                   empty
);

   logic [`ADDR_W-1:0]  cur_addr;
   logic [`LEN_W-1:0]   remain;
   logic [`BURST_W-1:0] blen;
   logic                load;
   logic                advance;

   // base broadcast carries the owning stage
   assign load = base_in.valid && (base_in.stage == `STAGE_W'(STAGE_ID));
   assign advance = take & cmd_valid;

   // capped at the all-ones burst length while more words remain
   assign blen = (|remain[`LEN_W-1:`BURST_W]) ? {`BURST_W{1'b1}} : remain[`BURST_W-1:0];

   assign cmd_valid = |remain;
   assign empty = ~cmd_valid;

   assign cmd = '{stage: `STAGE_W'(STAGE_ID), addr: cur_addr, len: blen};

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         remain <= '0;
      else if (load)
         remain <= shadow.len;
      else if (advance)
         remain <= remain - `LEN_W'(blen);
   end

   // next burst starts right after the one just taken
   always_ff @(posedge clk) begin
      if (load)
         cur_addr <= base_in.addr;
      else if (advance)
         cur_addr <= cur_addr + `ADDR_W'(blen);
   end

endmodule

// File: hdl/cmd_merge.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module cmd_merge (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`N_STAGES-1:0]  cmd_valid,
   input  burst_pkg::burst_cmd_t cmd_in [`N_STAGES],
   output logic [`N_STAGES-1:0]  take,
   output burst_pkg::burst_cmd_t cmd,
   output logic                  cmd_req,
   input  logic                  cmd_ack,
   output logic                  idle
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,
      S_REL,
      S_TAKE
   } state_t;

   state_t state;

   logic [`STAGE_W-1:0] rr_ptr;
   logic [`STAGE_W-1:0] pick;
   logic [`STAGE_W-1:0] sel;
   logic                found;

   // first valid stage at or after the round-robin pointer
   always_comb begin
      int idx;
      found = 1'b0;
      pick = rr_ptr;
      for (int k = 0; k < `N_STAGES; k++) begin
         idx = (int'(rr_ptr) + k) % `N_STAGES;
         if (!found && cmd_valid[idx]) begin
            found = 1'b1;
            pick = `STAGE_W'(idx);
         end
      end
   end

   // four-phase handshake
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= S_IDLE;
         rr_ptr <= '0;
         sel <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (found) begin
                  sel <= pick;
                  rr_ptr <= (pick == `STAGE_W'(`N_STAGES - 1)) ? '0 : pick + 1'b1;
                  state <= S_REQ;
               end
            end
            S_REQ: begin
               if (cmd_ack)
                  state <= S_REL;
            end
            S_REL: begin
               // wait for ack to fall before the transfer counts
               if (!cmd_ack)
                  state <= S_TAKE;
            end
            S_TAKE: begin
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // held stable for the whole request phase
   always_ff @(posedge clk) begin
      if (state == S_IDLE && found)
         cmd <= cmd_in[pick];
   end

   assign cmd_req = (state == S_REQ);
   assign idle = (state == S_IDLE);
   assign take = (state == S_TAKE) ? (`N_STAGES'(1) << sel) : '0;

endmodule

// File: hdl/burst_engine.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module burst_engine (
   input  logic                  clk,
   input  logic                  rst,
   input  burst_pkg::cpu_wr_t    cpu,
   input  logic                  run,
   output burst_pkg::burst_cmd_t cmd,
   output logic                  cmd_req,
   input  logic                  cmd_ack,
   output logic                  done
);

   burst_pkg::cfg_t       shadow;
   burst_pkg::stage_base_t base_bus;
   burst_pkg::burst_cmd_t gen_cmd [`N_STAGES];

   logic [`N_STAGES-1:0] gen_valid;
   logic [`N_STAGES-1:0] gen_take;
   logic [`N_STAGES-1:0] gen_empty;

   logic start;
   logic busy;
   logic idle;
   logic pend;
   logic last_base;

   assign busy = ~done;

   cfg_regs cfg_regs_inst (
      .clk(clk),
      .rst(rst),
      .cpu(cpu),
      .run(run),
      .busy(busy),
      .shadow(shadow),
      .start(start)
   );

   stage_base_calc stage_base_calc_inst (
      .clk(clk),
      .rst(rst),
      .start(start),
      .shadow(shadow),
      .base_out(base_bus)
   );

   for (genvar g = 0; g < `N_STAGES; g++) begin : gen_stage
      burst_gen #(
         .STAGE_ID(g)
      ) burst_gen_inst (
         .clk(clk),
         .rst(rst),
         .base_in(base_bus),
         .shadow(shadow),
         .cmd_valid(gen_valid[g]),
         .cmd(gen_cmd[g]),
         .take(gen_take[g]),
         .empty(gen_empty[g])
      );
   end

   cmd_merge cmd_merge_inst (
      .clk(clk),
      .rst(rst),
      .cmd_valid(gen_valid),
      .cmd_in(gen_cmd),
      .take(gen_take),
      .cmd(cmd),
      .cmd_req(cmd_req),
      .cmd_ack(cmd_ack),
      .idle(idle)
   );

   // stages look empty until their base has loaded
   assign last_base = base_bus.valid && (base_bus.stage == `STAGE_W'(`N_STAGES - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend <= 1'b0;
         done <= 1'b1;
      end else begin
         if (run && done)
            pend <= 1'b1;
         else if (last_base)
            pend <= 1'b0;
         done <= (&gen_empty) & idle & ~pend & ~(run & done);
      end
   end

endmodule

// File: bench/burst_engine_tb.sv
`timescale 1ns/1ps

`include "burst_macros.svh"

module burst_engine_tb;

   localparam int BURST_CAP = (1 << `BURST_W) - 1;
   localparam int DONE_TIMEOUT = 4000;
   localparam int ACK_TIMEOUT = 200;

   logic                  clk;
   logic                  rst;
   burst_pkg::cpu_wr_t    cpu;
   logic                  run;
   burst_pkg::burst_cmd_t cmd;
   logic                  cmd_req;
   logic                  cmd_ack;
   logic                  done;

   burst_pkg::burst_cmd_t exp_q [$];
   burst_pkg::burst_cmd_t prev_cmd;
   logic   prev_req = 1'b0;
   logic   prev_ack = 1'b0;
   integer seed = 32'h324b_9627;
   int     cmd_count;
   int     exp_total;

   burst_engine burst_engine_inst (
      .clk(clk),
      .rst(rst),
      .cpu(cpu),
      .run(run),
      .cmd(cmd),
      .cmd_req(cmd_req),
      .cmd_ack(cmd_ack),
      .done(done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic halt_with_failure();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic mismatch(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      halt_with_failure();
   endtask

   task automatic timed_out(input string what);
      $display("timeout: no %s within the cycle limit", what);
      halt_with_failure();
   endtask

   function automatic int next_delay();
      return $unsigned($random(seed)) % 6;
   endfunction

   // expected commands of every stage, in stage order
   function automatic void build_expected(input logic [`ADDR_W-1:0] base,
                                          input logic [`OFFSET_W-1:0] offset,
                                          input logic [`LEN_W-1:0] len);
      logic [`ADDR_W-1:0] addr;
      int remain;
      int blen;
      burst_pkg::burst_cmd_t c;
      exp_q.delete();
      for (int s = 0; s < `N_STAGES; s++) begin
         addr = base + `ADDR_W'(s) * `ADDR_W'(offset);
         remain = int'(len);
         while (remain > 0) begin
            blen = (remain > BURST_CAP) ? BURST_CAP : remain;
            c.stage = `STAGE_W'(s);
            c.addr = addr;
            c.len = `BURST_W'(blen);
            exp_q.push_back(c);
            addr = addr + `ADDR_W'(blen);
            remain = remain - blen;
         end
      end
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic write_reg(input logic [`CFG_ADDR_W-1:0] addr, input logic [`ADDR_W-1:0] data);
      cpu = '{valid: 1'b1, addr: addr, data: data};
      step();
      cpu = '0;
   endtask

   task automatic load_config(input logic [`ADDR_W-1:0] base,
                              input logic [`OFFSET_W-1:0] offset,
                              input logic [`LEN_W-1:0] len);
      write_reg(`REG_BASE, base);
      write_reg(`REG_OFFSET, `ADDR_W'(offset));
      write_reg(`REG_LEN, `ADDR_W'(len));
   endtask

   task automatic pulse_run();
      assert (done) else mismatch("done low before run");
      cmd_count = 0;
      exp_total = exp_q.size();
      run = 1'b1;
      step();
      run = 1'b0;
      assert (!done) else mismatch("done did not fall after run");
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (!done && cycles < DONE_TIMEOUT) begin
         step();
         cycles++;
      end
      if (!done)
         timed_out("return of done after a run");
      assert (exp_q.size() == 0 && cmd_count == exp_total)
         else mismatch($sformatf("%0d of %0d commands seen", cmd_count, exp_total));
      assert (!cmd_req && !cmd_ack) else mismatch("done rose during a handshake");
   endtask

   task automatic run_case(input logic [`ADDR_W-1:0] base,
                           input logic [`OFFSET_W-1:0] offset,
                           input logic [`LEN_W-1:0] len);
      load_config(base, offset, len);
      build_expected(base, offset, len);
      pulse_run();
      wait_done();
   endtask

   // ack follows req after a random number of cycles
   initial begin : ack_responder
      int delay;
      int held;
      cmd_ack = 1'b0;
      held = 0;
      delay = next_delay();
      forever begin
         step();
         if (cmd_req != cmd_ack) begin
            if (delay > 0) begin
               delay--;
            end else begin
               cmd_ack = cmd_req;
               delay = next_delay();
            end
         end
         held = (cmd_req && cmd_ack) ? held + 1 : 0;
         if (held > ACK_TIMEOUT)
            timed_out("release of cmd_req after cmd_ack");
      end
   end

   always @(posedge cmd_ack) begin : cmd_check
      int idx;
      burst_pkg::burst_cmd_t got;
      got = cmd;
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
         if (idx < 0 && exp_q[i].stage == got.stage)
            idx = i;
      end
      cmd_count++;
      assert (idx >= 0) else mismatch($sformatf("unexpected command from stage %0d", got.stage));
      if (idx >= 0) begin
         assert (got == exp_q[idx])
            else mismatch($sformatf("stage %0d got addr %h len %0d, expected addr %h len %0d",
                                    got.stage, got.addr, got.len, exp_q[idx].addr,
                                    exp_q[idx].len));
         exp_q.delete(idx);
      end
   end

   // sampled mid-cycle, away from both edges
   always @(negedge clk) begin : protocol_monitor
      if (!rst) begin
         if (prev_req && !cmd_req)
            assert (prev_ack) else mismatch("cmd_req fell before cmd_ack rose");
         if (!prev_req && cmd_req)
            assert (!prev_ack) else mismatch("cmd_req rose while cmd_ack was high");
         if (prev_req && cmd_req)
            assert (cmd == prev_cmd) else mismatch("cmd changed while cmd_req was high");
      end
      prev_req = cmd_req;
      prev_ack = cmd_ack;
      prev_cmd = cmd;
   end

   initial begin : stimulus
      logic [`ADDR_W-1:0]   base;
      logic [`OFFSET_W-1:0] offset;
      logic [`LEN_W-1:0]    len;
      rst = 1'b1;
      cpu = '0;
      run = 1'b0;
      cmd_count = 0;
      exp_total = 0;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      step();
      assert (done && !cmd_req) else mismatch("done low or cmd_req high after reset");
      run_case(32'h1000_0000, 16'h0100, 16'd3);
      // three bursts per stage
      run_case(32'h2000_0000, 16'h1000, 16'd600);
      // crosses the top of the address space
      run_case(32'hffff_ff00, 16'h0010, 16'd600);
      run_case(32'h3000_0000, 16'h0200, 16'd0);
      // rewrite during a run, then rerun with the new values
      load_config(32'h4000_0000, 16'h0040, 16'd300);
      build_expected(32'h4000_0000, 16'h0040, 16'd300);
      pulse_run();
      load_config(32'h5000_0000, 16'h0080, 16'd20);
      wait_done();
      build_expected(32'h5000_0000, 16'h0080, 16'd20);
      pulse_run();
      wait_done();
      for (int i = 0; i < 4; i++) begin
         base = $random(seed);
         offset = 16'($random(seed));
         len = 16'($unsigned($random(seed)) % 800);
         run_case(base, offset, len);
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: src.f
+incdir+include
hdl/burst_pkg.sv
hdl/cfg_regs.sv
hdl/stage_base_calc.sv
hdl/burst_gen.sv
hdl/cmd_merge.sv
hdl/burst_engine.sv
bench/burst_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module burst_engine_tb -f src.f; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vburst_engine_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
